/* Makefile */
TOP = esaxi_tb
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 -f filelist.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Test passed" $(LOG)

lint:
	verilator --lint-only -Wall --timing -f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

/* filelist.f */
+incdir+verilog
verilog/emesh_pkg.sv
verilog/esaxi_decode.sv
verilog/esaxi_execute.sv
verilog/esaxi_result.sv
verilog/mesh_mem.sv
verilog/esaxi_top.sv
tests/esaxi_tb.sv

/* tests/esaxi_tb.sv */
`timescale 1ns/100ps
`include "emesh_macros.svh"

module esaxi_tb;
   import emesh_pkg::*;

   // one row per axi transaction
   typedef struct {
      bit                   is_write;
      logic [`AXI_IDW-1:0]  id;
      logic [`EMESH_AW-1:0] addr;
      logic [7:0]           len;        // beats minus one
      logic [2:0]           size;
      axi_burst_t           burst;
      logic [3:0]           strb;
      logic [15:0]          stall;      // mesh_stall per cycle from row start
      int                   delay;      // bready or rready hold-off
      axi_resp_t            exp_resp;
   } row_t;

   localparam int unsigned n_rows      = 17;
   localparam int unsigned cycle_limit = n_rows * 64;

   bit                   s_axi_aclk;
   logic                 s_axi_aresetn;
   logic [`AXI_IDW-1:0]  awid, arid, bid, rid;
   logic [`EMESH_AW-1:0] awaddr, araddr;
   logic [7:0]           awlen, arlen;
   logic [2:0]           awsize, arsize;
   logic [1:0]           awburst, arburst, bresp, rresp;
   logic                 awvalid, awready, wlast, wvalid, wready;
   logic [`EMESH_DW-1:0] wdata, rdata;
   logic [3:0]           wstrb;
   logic                 bvalid, bready, arvalid, arready, rlast, rvalid, rready;
   logic                 mesh_stall;

   row_t        rows [n_rows];
   logic [7:0]  ref_mem [256];          // byte model of mesh_mem
   int unsigned cycle_count;
   int unsigned row_base;                // cycle where the current row began
   int unsigned row_ofs;
   bit   [15:0] stall_pat;

   esaxi_top i_dut (.*);

   always #5 s_axi_aclk = ~s_axi_aclk;  // 10 ns

   // stall follows the row's pattern, changes only after a rising edge
   assign row_ofs    = cycle_count - row_base;
   assign mesh_stall = (row_ofs < 16) ? stall_pat[row_ofs[3:0]] : 1'b0;

   always @(posedge s_axi_aclk)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= cycle_limit)
         halt_run("timeout, the DUT stopped answering before the table was done");
   end

   // ##########################################################################
   // error reporting and compares
   // ##########################################################################
   task automatic halt_run(input string reason);
      $display("%s", reason);
      $display("Test failed");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic compare_data(input string what, input logic [`EMESH_DW-1:0] got,
                               input logic [`EMESH_DW-1:0] exp);
      if (got !== exp)
         halt_run($sformatf("mismatch at %0d ns: %s got %h expected %h", $time, what, got, exp));
   endtask

   task automatic compare_resp(input string what, input axi_resp_t got, input axi_resp_t exp);
      if (got !== exp)
         halt_run($sformatf("mismatch at %0d ns: %s got %s expected %s", $time, what,
                            got.name(), exp.name()));
   endtask

   task automatic compare_id(input string what, input logic [`AXI_IDW-1:0] got,
                             input logic [`AXI_IDW-1:0] exp);
      if (got !== exp)
         halt_run($sformatf("mismatch at %0d ns: %s got %h expected %h", $time, what, got, exp));
   endtask

   // ##########################################################################
   // reference model
   // ##########################################################################
   function automatic int lowest_lane(input logic [3:0] strb);
      for (int i = 0; i < 4; i++)
         if (strb[i])
            return i;
      return 3;                          // no strobe lands on the top lane
   endfunction

   // incr steps whole words, fixed and wrap stay put
   function automatic logic [`EMESH_AW-1:0] beat_addr(input logic [`EMESH_AW-1:0] start,
                                                      input axi_burst_t burst, input int beat);
      if (burst == burst_incr && beat > 0)
         return {start[`EMESH_AW-1:2] + beat[29:0], 2'b00};
      return start;
   endfunction

   function automatic void write_reference(input logic [`EMESH_AW-1:0] addr,
                                           input logic [2:0] size, input logic [3:0] strb,
                                           input logic [`EMESH_DW-1:0] data);
      int         lane;
      int         nbytes;
      logic [7:0] idx;
      lane   = (size == 3'd2) ? 0 : lowest_lane(strb);  // words ignore strobes
      nbytes = (size == 3'd2) ? 4 : ((size == 3'd1) ? 2 : 1);
      for (int b = lane; b < lane + nbytes && b < 4; b++)
      begin
         idx          = {addr[7:2], 2'b00} + 8'(b);
         ref_mem[idx] = data[8*b +: 8];
      end
   endfunction

   // narrow reads come back copied onto every lane
   function automatic logic [`EMESH_DW-1:0] expected_read(input logic [`EMESH_AW-1:0] addr,
                                                          input logic [2:0] size);
      logic [7:0] a;
      a = addr[7:0];
      case (size)
         3'd0:    return {4{ref_mem[a]}};
         3'd1:    return {2{ref_mem[a + 8'd1], ref_mem[a]}};
         default: return {ref_mem[a + 8'd3], ref_mem[a + 8'd2], ref_mem[a + 8'd1], ref_mem[a]};
      endcase
   endfunction

   // ##########################################################################
   // stimulus table
   // ##########################################################################
   task automatic load_table();
      // wr    id       addr        len   size  burst        strb  stall     dly  resp
      rows[0]  = '{1'b1, 12'h001, 32'h10, 8'd0, 3'd2, burst_incr,  4'hf, 16'h0000, 0, resp_okay};
      rows[1]  = '{1'b0, 12'h002, 32'h10, 8'd0, 3'd2, burst_incr,  4'h0, 16'h0000, 0, resp_okay};
      rows[2]  = '{1'b1, 12'h0a3, 32'h20, 8'd3, 3'd2, burst_incr,  4'hf, 16'h0000, 1, resp_okay};
      rows[3]  = '{1'b0, 12'h0a4, 32'h20, 8'd3, 3'd2, burst_incr,  4'h0, 16'h0000, 2, resp_okay};
      rows[4]  = '{1'b1, 12'h105, 32'h22, 8'd0, 3'd0, burst_incr,  4'h4, 16'h0000, 0, resp_okay};
      rows[5]  = '{1'b0, 12'h106, 32'h22, 8'd0, 3'd0, burst_incr,  4'h0, 16'h0000, 0, resp_okay};
      rows[6]  = '{1'b0, 12'h107, 32'h22, 8'd0, 3'd1, burst_incr,  4'h0, 16'h0000, 1, resp_okay};
      rows[7]  = '{1'b0, 12'h108, 32'h20, 8'd0, 3'd2, burst_incr,  4'h0, 16'h0000, 0, resp_okay};
      rows[8]  = '{1'b1, 12'h209, 32'h40, 8'd3, 3'd2, burst_incr,  4'hf, 16'h0000, 0, resp_okay};
      rows[9]  = '{1'b1, 12'h20a, 32'h40, 8'd2, 3'd2, burst_fixed, 4'hf, 16'h0000, 0, resp_okay};
      rows[10] = '{1'b1, 12'h30b, 32'h48, 8'd2, 3'd2, burst_wrap,  4'hf, 16'h0000, 2, resp_okay};
      rows[11] = '{1'b0, 12'h30c, 32'h40, 8'd3, 3'd2, burst_incr,  4'h0, 16'h0000, 0, resp_okay};
      rows[12] = '{1'b1, 12'h40d, 32'h60, 8'd3, 3'd2, burst_incr,  4'hf, 16'h00cc, 3, resp_okay};
      rows[13] = '{1'b0, 12'h40e, 32'h60, 8'd3, 3'd2, burst_incr,  4'h0, 16'h0000, 1, resp_okay};
      rows[14] = '{1'b1, 12'h50f, 32'h12, 8'd0, 3'd1, burst_incr,  4'hc, 16'h0000, 0, resp_okay};
      rows[15] = '{1'b0, 12'h510, 32'h10, 8'd0, 3'd2, burst_incr,  4'h0, 16'h0000, 0, resp_okay};
      rows[16] = '{1'b0, 12'h511, 32'h12, 8'd0, 3'd1, burst_fixed, 4'h0, 16'h0000, 0, resp_okay};
   endtask

   // ##########################################################################
   // axi drivers, entered and left right after a rising edge
   // ##########################################################################
   task automatic run_write(input row_t r);
      logic [`EMESH_DW-1:0] data;
      awid      <= r.id;
      awaddr    <= r.addr;
      awlen     <= r.len;
      awsize    <= r.size;
      awburst   <= r.burst;
      awvalid   <= 1'b1;
      stall_pat <= r.stall;
      row_base  <= cycle_count;
      @(negedge s_axi_aclk);
      while (!awready)
         @(negedge s_axi_aclk);
      @(posedge s_axi_aclk);             // aw taken here
      awvalid <= 1'b0;
      for (int k = 0; k <= int'(r.len); k++)
      begin
         data = $urandom;
         wdata  <= data;
         wstrb  <= r.strb;
         wlast  <= (k == int'(r.len));
         wvalid <= 1'b1;
         @(negedge s_axi_aclk);
         while (!wready)                 // paused by mesh stall
            @(negedge s_axi_aclk);
         @(posedge s_axi_aclk);
         write_reference(beat_addr(r.addr, r.burst, k), r.size, r.strb, data);
      end
      wvalid <= 1'b0;
      wlast  <= 1'b0;
      @(negedge s_axi_aclk);
      while (!bvalid)
         @(negedge s_axi_aclk);
      repeat (r.delay)
      begin
         if (awready)
            halt_run("awready came back while the write response was still pending");
         @(negedge s_axi_aclk);
         if (!bvalid)
            halt_run("bvalid dropped before bready was raised");
      end
      @(posedge s_axi_aclk);
      bready <= 1'b1;
      @(negedge s_axi_aclk);
      compare_id("bid", bid, r.id);
      compare_resp("bresp", axi_resp_t'(bresp), r.exp_resp);
      @(posedge s_axi_aclk);             // b handshake
      bready <= 1'b0;
   endtask

   task automatic run_read(input row_t r);
      logic exp_last;
      arid      <= r.id;
      araddr    <= r.addr;
      arlen     <= r.len;
      arsize    <= r.size;
      arburst   <= r.burst;
      arvalid   <= 1'b1;
      stall_pat <= r.stall;
      row_base  <= cycle_count;
      @(negedge s_axi_aclk);
      while (!arready)
         @(negedge s_axi_aclk);
      @(posedge s_axi_aclk);
      arvalid <= 1'b0;
      for (int k = 0; k <= int'(r.len); k++)
      begin
         exp_last = (k == int'(r.len));
         @(negedge s_axi_aclk);
         while (!rvalid)
            @(negedge s_axi_aclk);
         repeat (r.delay)
         begin
            @(negedge s_axi_aclk);
            if (!rvalid)
               halt_run("rvalid dropped while rready was low");
         end
         @(posedge s_axi_aclk);
         rready <= 1'b1;
         @(negedge s_axi_aclk);          // beat stable, taken at the next edge
         compare_data("rdata", rdata, expected_read(beat_addr(r.addr, r.burst, k), r.size));
         compare_data("rlast", {31'd0, rlast}, {31'd0, exp_last});
         compare_id("rid", rid, r.id);
         compare_resp("rresp", axi_resp_t'(rresp), r.exp_resp);
         @(posedge s_axi_aclk);
         rready <= 1'b0;
      end
   endtask

   initial
   begin
      void'($urandom(65654));
      s_axi_aresetn = 1'b0;
      awid    = '0;
      awaddr  = '0;
      awlen   = '0;
      awsize  = '0;
      awburst = '0;
      awvalid = 1'b0;
      wdata   = '0;
      wstrb   = '0;
      wlast   = 1'b0;
      wvalid  = 1'b0;
      bready  = 1'b0;
      arid    = '0;
      araddr  = '0;
      arlen   = '0;
      arsize  = '0;
      arburst = '0;
      arvalid = 1'b0;
      rready  = 1'b0;
      load_table();
      repeat (3) @(posedge s_axi_aclk);
      s_axi_aresetn <= 1'b1;
      for (int i = 0; i < int'(n_rows); i++)
      begin
         if (rows[i].is_write)
            run_write(rows[i]);
         else
            run_read(rows[i]);
      end
      $display("Test passed");
      $finish;
   end

endmodule

/* verilog/emesh_macros.svh */
`ifndef EMESH_MACROS_SVH
`define EMESH_MACROS_SVH

// mesh packet and bus widths
`define EMESH_PW        104      // full packet incl access bit
`define EMESH_AW        32       // mesh address
`define EMESH_DW        32       // mesh data, no 64b transfers

`define AXI_IDW         12       // axi id width on aw/ar/b/r

// node identity for read replies
`define EMESH_ID        12'h810
`define EGROUP_RR       4'hd     // read-reply group
`define RETURN_ADDR     {`EMESH_ID, `EGROUP_RR}

// target memory depth, 64 words
`define MEM_WORDS_LOG2  6

`endif

/* verilog/emesh_pkg.sv */
`include "emesh_macros.svh"

package emesh_pkg;

   // mesh transfer size, same code as axi size[1:0]
   typedef enum logic [1:0] {
      dm_byte   = 2'd0,
      dm_half   = 2'd1,
      dm_word   = 2'd2,
      dm_double = 2'd3     // not used by this bridge
   } datamode_t;

   typedef enum logic [1:0] {
      burst_fixed = 2'd0,
      burst_incr  = 2'd1,
      burst_wrap  = 2'd2   // handled like fixed
   } axi_burst_t;

   typedef enum logic [1:0] {
      resp_okay   = 2'd0,
      resp_exokay = 2'd1,
      resp_slverr = 2'd2,
      resp_decerr = 2'd3
   } axi_resp_t;

   // write channel fsm
   typedef enum logic [1:0] {
      wr_idle = 2'd0,    // waiting for aw
      wr_data = 2'd1,    // taking w beats
      wr_resp = 2'd2     // holding b until accepted
   } wr_state_t;

   typedef logic [`EMESH_PW-1:0] emesh_packet_t;

   // ##########################################################################
   // packet layout, lsb first
   //   [0] access  [1] write  [3:2] datamode  [7:4] ctrlmode
   //   [39:8] dstaddr  [71:40] data  [103:72] srcaddr
   // ##########################################################################
   typedef struct packed {
      logic [`EMESH_AW-1:0] srcaddr;
      logic [`EMESH_DW-1:0] data;
      logic [`EMESH_AW-1:0] dstaddr;
      logic [3:0]           ctrlmode;
      datamode_t            datamode;
      logic                 write;
      logic                 access;
   } emesh_fields_t;

   function automatic emesh_packet_t emesh_pack(
      input logic                 access,
      input logic                 write,
      input datamode_t            datamode,
      input logic [3:0]           ctrlmode,
      input logic [`EMESH_AW-1:0] dstaddr,
      input logic [`EMESH_DW-1:0] data,
      input logic [`EMESH_AW-1:0] srcaddr
   );
      return {srcaddr, data, dstaddr, ctrlmode, datamode, write, access};
   endfunction

   function automatic emesh_fields_t emesh_unpack(input emesh_packet_t packet);
      emesh_fields_t f;
      f.access   = packet[0];
      f.write    = packet[1];
      f.datamode = datamode_t'(packet[3:2]);
      f.ctrlmode = packet[7:4];
      f.dstaddr  = packet[39:8];
      f.data     = packet[71:40];
      f.srcaddr  = packet[103:72];
      return f;
   endfunction

endpackage

/* verilog/esaxi_decode.sv */
`timescale 1ns/100ps
`include "emesh_macros.svh"

module esaxi_decode (
   input  logic                    s_axi_aclk,
   input  logic                    s_axi_aresetn,
   // write address
   input  logic [`AXI_IDW-1:0]     awid,
   input  logic [`EMESH_AW-1:0]    awaddr,
   input  logic [7:0]              awlen,
   input  logic [2:0]              awsize,
   input  emesh_pkg::axi_burst_t   awburst,
   input  logic                    awvalid,
   output logic                    awready,
   // write data, payload goes straight to execute
   input  logic                    wlast,
   input  logic                    wvalid,
   output logic                    wready,
   // write response
   output logic [`AXI_IDW-1:0]     bid,
   output emesh_pkg::axi_resp_t    bresp,
   output logic                    bvalid,
   input  logic                    bready,
   // read address
   input  logic [`AXI_IDW-1:0]     arid,
   input  logic [`EMESH_AW-1:0]    araddr,
   input  logic [7:0]              arlen,
   input  logic [2:0]              arsize,
   input  emesh_pkg::axi_burst_t   arburst,
   input  logic                    arvalid,
   output logic                    arready,
   // read data bookkeeping, data itself comes from result
   output logic [`AXI_IDW-1:0]     rid,
   output logic                    rlast,
   input  logic                    rready,
   input  logic                    rvalid,
   // mesh write back-pressure
   input  logic                    txwr_wait,
   // to execute
   output logic                    w_beat,
   output logic [`EMESH_AW-1:0]    wr_addr,
   output emesh_pkg::datamode_t    wr_size,
   output logic                    rd_start,
   output logic                    rd_next,
   output logic [`EMESH_AW-1:0]    rd_addr,
   output emesh_pkg::datamode_t    rd_size
);
   import emesh_pkg::*;

   wr_state_t  wr_state;
   axi_burst_t wr_burst;         // captured aw burst type
   axi_burst_t rd_burst;
   logic [7:0] wr_len;           // beats left after the current one
   logic [7:0] rd_len;
   logic       aw_hs;
   logic       ar_hs;
   logic       b_hs;
   logic       r_beat;
   logic       last_wr_beat;
   logic       last_rd_beat;
   logic       read_active;      // one read burst in flight
   logic       read_active_q;    // for the leading edge

   assign aw_hs        = awready & awvalid;
   assign ar_hs        = arready & arvalid;
   assign b_hs         = bvalid & bready;
   assign w_beat       = wready & wvalid;
   assign r_beat       = rvalid & rready;
   // wlast normally ends it, the length count is a backstop
   assign last_wr_beat = w_beat & (wlast | (wr_len == 8'd0));
   assign last_rd_beat = r_beat & rlast;

   assign bresp = resp_okay;     // no error responses

   // ##########################################################################
   // write channel
   // ##########################################################################
   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         wr_state <= wr_idle;
         awready  <= 1'b1;          // ready for an address out of reset
         wready   <= 1'b0;
         bvalid   <= 1'b0;
         wr_len   <= 8'd0;
      end
      else
      begin
         case (wr_state)
            wr_idle:
               if (aw_hs)
               begin
                  wr_state <= wr_data;
                  awready  <= 1'b0;
               end
            wr_data:
               if (last_wr_beat)
               begin
                  wr_state <= wr_resp;
                  bvalid   <= 1'b1;  // b one cycle after last beat
               end
            wr_resp:
               if (b_hs)
               begin
                  wr_state <= wr_idle;
                  bvalid   <= 1'b0;
                  awready  <= 1'b1;  // next aw only once b is gone
               end
            default:
               wr_state <= wr_idle;
         endcase

         // mesh stall drops wready on the next cycle
         wready <= ~txwr_wait & (aw_hs | ((wr_state == wr_data) & ~last_wr_beat));

         if (aw_hs)
            wr_len <= awlen;
         else if (w_beat)
            wr_len <= wr_len - 8'd1;
      end
   end

   // aw capture and beat address
   always_ff @(posedge s_axi_aclk)
   begin
      if (aw_hs)
      begin
         bid      <= awid;          // echoed on b
         wr_addr  <= awaddr;
         wr_size  <= datamode_t'(awsize[1:0]);
         wr_burst <= awburst;
      end
      else if (w_beat && wr_burst == burst_incr)
         wr_addr <= {wr_addr[`EMESH_AW-1:2] + 30'd1, 2'b00};  // next word, aligned
      // fixed and wrap keep the start address
   end

   // ##########################################################################
   // read channel
   // ##########################################################################
   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         arready       <= 1'b0;
         read_active   <= 1'b0;
         read_active_q <= 1'b0;
         rd_start      <= 1'b0;
         rd_next       <= 1'b0;
         rlast         <= 1'b0;
         rd_len        <= 8'd0;
      end
      else
      begin
         if (ar_hs)
            arready <= 1'b0;
         else if (!read_active)
            arready <= 1'b1;        // rises a cycle after reset

         if (ar_hs)
            read_active <= 1'b1;
         else if (last_rd_beat)
            read_active <= 1'b0;

         read_active_q <= read_active;
         rd_start      <= read_active & ~read_active_q;  // first request
         rd_next       <= r_beat & ~rlast;                // one request per beat

         if (ar_hs)
         begin
            rd_len <= arlen;
            rlast  <= (arlen == 8'd0);  // single beat read
         end
         else if (r_beat)
         begin
            rd_len <= rd_len - 8'd1;
            if (rd_len == 8'd1)
               rlast <= 1'b1;
         end
      end
   end

   // ar capture and beat address
   always_ff @(posedge s_axi_aclk)
   begin
      if (ar_hs)
      begin
         rid      <= arid;
         rd_addr  <= araddr;
         rd_size  <= datamode_t'(arsize[1:0]);
         rd_burst <= arburst;
      end
      else if (r_beat && rd_burst == burst_incr)
         rd_addr <= {rd_addr[`EMESH_AW-1:2] + 30'd1, 2'b00};
   end

endmodule

/* verilog/esaxi_execute.sv */
`timescale 1ns/100ps
`include "emesh_macros.svh"

module esaxi_execute (
   input  logic                    s_axi_aclk,
   input  logic                    s_axi_aresetn,
   input  logic                    w_beat,
   input  logic [`EMESH_DW-1:0]    wdata,
   input  logic [3:0]              wstrb,
   input  logic [`EMESH_AW-1:0]    wr_addr,
   input  emesh_pkg::datamode_t    wr_size,
   input  logic                    rd_start,
   input  logic                    rd_next,
   input  logic [`EMESH_AW-1:0]    rd_addr,
   input  emesh_pkg::datamode_t    rd_size,
   output logic                    txwr_access,
   output emesh_pkg::emesh_packet_t txwr_packet,
   output logic                    txrd_access,
   output emesh_pkg::emesh_packet_t txrd_packet
);
   import emesh_pkg::*;

   logic [1:0]           lane;        // lowest strobed byte
   logic [`EMESH_DW-1:0] steer_data;
   // enable stage
   logic                 wr_en_q;
   logic [`EMESH_DW-1:0] wr_data_q;
   logic [`EMESH_AW-1:0] wr_dst_q;
   datamode_t            wr_mode_q;
   // access stage
   logic [`EMESH_DW-1:0] tx_data;
   logic [`EMESH_AW-1:0] tx_dst;
   datamode_t            tx_mode;
   // read request
   logic [`EMESH_AW-1:0] rd_dst;
   datamode_t            rd_mode;

   // word writes always start at lane 0
   always_comb
   begin
      if (wstrb[0] || wr_size == dm_word)
         lane = 2'd0;
      else if (wstrb[1])
         lane = 2'd1;
      else if (wstrb[2])
         lane = 2'd2;
      else
         lane = 2'd3;
   end

   assign steer_data = wdata >> {lane, 3'b000};  // right-align the lane

   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         wr_en_q     <= 1'b0;
         txwr_access <= 1'b0;
         txrd_access <= 1'b0;
      end
      else
      begin
         wr_en_q     <= w_beat;
         txwr_access <= wr_en_q;            // two cycles after the w beat
         txrd_access <= rd_start | rd_next;
      end
   end

   // payload follows the access bits stage by stage
   always_ff @(posedge s_axi_aclk)
   begin
      wr_data_q <= steer_data;
      wr_dst_q  <= {wr_addr[`EMESH_AW-1:2], lane};
      wr_mode_q <= wr_size;
      tx_data   <= wr_data_q;
      tx_dst    <= wr_dst_q;
      tx_mode   <= wr_mode_q;
      rd_dst    <= rd_addr;
      rd_mode   <= rd_size;
   end

   assign txwr_packet = emesh_pack(txwr_access, 1'b1, tx_mode, 4'h0, tx_dst, tx_data,
                                   {`EMESH_AW{1'b0}});
   // reply comes back to our node, read-reply group
   assign txrd_packet = emesh_pack(txrd_access, 1'b0, rd_mode, 4'h0, rd_dst,
                                   {`EMESH_DW{1'b0}}, {`RETURN_ADDR, 16'h0000});

endmodule

/* verilog/esaxi_result.sv */
`timescale 1ns/100ps
`include "emesh_macros.svh"

module esaxi_result (
   input  logic                     s_axi_aclk,
   input  logic                     s_axi_aresetn,
   input  logic                     rxrr_access,
   input  emesh_pkg::emesh_packet_t rxrr_packet,
   input  emesh_pkg::datamode_t     rd_size,
   input  logic                     rready,
   output logic                     rvalid,
   output logic [`EMESH_DW-1:0]     rdata,
   output emesh_pkg::axi_resp_t     rresp
);
   import emesh_pkg::*;

   emesh_fields_t        rr_f;
   logic [`EMESH_DW-1:0] rep_data;   // replicated onto all lanes

   assign rr_f = emesh_unpack(rxrr_packet);

   // reply data arrives right-aligned
   always_comb
   begin
      case (rd_size)
         dm_byte: rep_data = {4{rr_f.data[7:0]}};
         dm_half: rep_data = {2{rr_f.data[15:0]}};
         default: rep_data = rr_f.data;
      endcase
   end

   // one read outstanding so a reply never lands on a held beat
   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
         rvalid <= 1'b0;
      else if (rxrr_access)
         rvalid <= 1'b1;
      else if (rready)
         rvalid <= 1'b0;            // held while rready low
   end

   always_ff @(posedge s_axi_aclk)
   begin
      if (rxrr_access)
         rdata <= rep_data;
   end

   assign rresp = resp_okay;

endmodule

/* verilog/esaxi_top.sv */
`timescale 1ns/100ps
`include "emesh_macros.svh"

module esaxi_top (
   input  logic                  s_axi_aclk,
   input  logic                  s_axi_aresetn,
   input  logic [`AXI_IDW-1:0]   awid,
   input  logic [`EMESH_AW-1:0]  awaddr,
   input  logic [7:0]            awlen,
   input  logic [2:0]            awsize,
   input  logic [1:0]            awburst,
   input  logic                  awvalid,
   output logic                  awready,
   input  logic [`EMESH_DW-1:0]  wdata,
   input  logic [3:0]            wstrb,
   input  logic                  wlast,
   input  logic                  wvalid,
   output logic                  wready,
   output logic [`AXI_IDW-1:0]   bid,
   output logic [1:0]            bresp,
   output logic                  bvalid,
   input  logic                  bready,
   input  logic [`AXI_IDW-1:0]   arid,
   input  logic [`EMESH_AW-1:0]  araddr,
   input  logic [7:0]            arlen,
   input  logic [2:0]            arsize,
   input  logic [1:0]            arburst,
   input  logic                  arvalid,
   output logic                  arready,
   output logic [`AXI_IDW-1:0]   rid,
   output logic [`EMESH_DW-1:0]  rdata,
   output logic [1:0]            rresp,
   output logic                  rlast,
   output logic                  rvalid,
   input  logic                  rready,
   input  logic                  mesh_stall     // target side stall
);
   import emesh_pkg::*;

   logic                 w_beat;
   logic [`EMESH_AW-1:0] wr_addr;
   datamode_t            wr_size;
   logic                 rd_start;
   logic                 rd_next;
   logic [`EMESH_AW-1:0] rd_addr;
   datamode_t            rd_size;
   logic                 txwr_access;
   emesh_packet_t        txwr_packet;
   logic                 txwr_wait;
   logic                 txrd_access;
   emesh_packet_t        txrd_packet;
   logic                 rxrr_access;
   emesh_packet_t        rxrr_packet;

   esaxi_decode i_decode (
      .s_axi_aclk, .s_axi_aresetn,
      .awid, .awaddr, .awlen, .awsize,
      .awburst (axi_burst_t'(awburst)),
      .awvalid, .awready,
      .wlast, .wvalid, .wready,
      .bid, .bresp, .bvalid, .bready,
      .arid, .araddr, .arlen, .arsize,
      .arburst (axi_burst_t'(arburst)),
      .arvalid, .arready,
      .rid, .rlast, .rready, .rvalid,
      .txwr_wait,
      .w_beat, .wr_addr, .wr_size,
      .rd_start, .rd_next, .rd_addr, .rd_size
   );

   esaxi_execute i_execute (
      .s_axi_aclk, .s_axi_aresetn,
      .w_beat, .wdata, .wstrb, .wr_addr, .wr_size,
      .rd_start, .rd_next, .rd_addr, .rd_size,
      .txwr_access, .txwr_packet, .txrd_access, .txrd_packet
   );

   esaxi_result i_result (
      .s_axi_aclk, .s_axi_aresetn,
      .rxrr_access, .rxrr_packet, .rd_size, .rready,
      .rvalid, .rdata, .rresp
   );

   mesh_mem i_mesh_mem (
      .s_axi_aclk, .s_axi_aresetn, .mesh_stall,
      .txwr_access, .txwr_packet, .txrd_access, .txrd_packet,
      .txwr_wait, .rxrr_access, .rxrr_packet
   );

endmodule

/* verilog/mesh_mem.sv */
`timescale 1ns/100ps
`include "emesh_macros.svh"

module mesh_mem (
   input  logic                     s_axi_aclk,
   input  logic                     s_axi_aresetn,
   input  logic                     mesh_stall,
   input  logic                     txwr_access,
   input  emesh_pkg::emesh_packet_t txwr_packet,
   input  logic                     txrd_access,
   input  emesh_pkg::emesh_packet_t txrd_packet,
   output logic                     txwr_wait,
   output logic                     rxrr_access,
   output emesh_pkg::emesh_packet_t rxrr_packet
);
   import emesh_pkg::*;

   localparam int mem_words = 1 << `MEM_WORDS_LOG2;

   logic [`EMESH_DW-1:0]       mem [mem_words];
   emesh_fields_t              wr_f;
   emesh_fields_t              rd_f;
   logic [`MEM_WORDS_LOG2-1:0] wr_idx;
   logic [`MEM_WORDS_LOG2-1:0] rd_idx;
   logic [1:0]                 wr_ofs;     // byte offset in the word
   logic [3:0]                 wr_be;
   logic [`EMESH_DW-1:0]       wr_word;    // data moved onto its lanes
   logic [`EMESH_DW-1:0]       rd_word;
   logic [`EMESH_DW-1:0]       rd_align;
   logic [`EMESH_AW-1:0]       rr_dst;
   logic [`EMESH_DW-1:0]       rr_data;
   datamode_t                  rr_mode;

   assign txwr_wait = mesh_stall;           // stall seen as write wait level

   assign wr_f   = emesh_unpack(txwr_packet);
   assign rd_f   = emesh_unpack(txrd_packet);
   assign wr_idx = wr_f.dstaddr[`MEM_WORDS_LOG2+1:2];
   assign rd_idx = rd_f.dstaddr[`MEM_WORDS_LOG2+1:2];
   assign wr_ofs = (wr_f.datamode == dm_word) ? 2'd0 : wr_f.dstaddr[1:0];

   always_comb
   begin
      case (wr_f.datamode)
         dm_byte: wr_be = 4'b0001 << wr_ofs;
         dm_half: wr_be = 4'b0011 << wr_ofs;
         default: wr_be = 4'b1111;
      endcase
   end

   assign wr_word = wr_f.data << {wr_ofs, 3'b000};

   // byte-lane writes, no wait of its own
   always_ff @(posedge s_axi_aclk)
   begin
      if (txwr_access)
         for (int i = 0; i < 4; i++)
            if (wr_be[i])
               mem[wr_idx][8*i +: 8] <= wr_word[8*i +: 8];
   end

   assign rd_word = mem[rd_idx] >> {rd_f.dstaddr[1:0], 3'b000};

   always_comb
   begin
      case (rd_f.datamode)
         dm_byte: rd_align = {24'h0, rd_word[7:0]};
         dm_half: rd_align = {16'h0, rd_word[15:0]};
         default: rd_align = rd_word;
      endcase
   end

   // reply one cycle after the request
   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
         rxrr_access <= 1'b0;
      else
         rxrr_access <= txrd_access;
   end

   always_ff @(posedge s_axi_aclk)
   begin
      if (txrd_access)
      begin
         rr_dst  <= rd_f.srcaddr;           // back to the requester
         rr_data <= rd_align;
         rr_mode <= rd_f.datamode;
      end
   end

   assign rxrr_packet = emesh_pack(rxrr_access, 1'b1, rr_mode, 4'h0, rr_dst, rr_data,
                                   {`EMESH_AW{1'b0}});

endmodule
